// ==== verilog/eeprom_pkg.sv ====
package eeprom_pkg;

    localparam int NUM_CHAN = 2;
    localparam int CHAN_W   = 1;
    localparam int ADDR_W   = 11;
    localparam int DATA_W   = 8;

    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    localparam int QUARTER = 2;                // CLK cycles per quarter scl period
    localparam int QCNT_W  = $clog2(QUARTER);

    // one-hot phase bit positions of the bus controller
    localparam int P_IDLE    = 0;
    localparam int P_START   = 1;
    localparam int P_CTRL_WR = 2;
    localparam int P_ADDR    = 3;
    localparam int P_DATA    = 4;
    localparam int P_RSTART  = 5;
    localparam int P_CTRL_RD = 6;
    localparam int P_DATA_RD = 7;
    localparam int P_STOP    = 8;
    localparam int P_DONE    = 9;
    localparam int NUM_PHASE = 10;

    typedef struct packed {
        logic              write;
        logic [CHAN_W-1:0] chan;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } eeprom_req_t;

    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } ctrl_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              nack;
    } ctrl_rsp_t;

    typedef struct packed {
        logic [CHAN_W-1:0] chan;
        logic              write;
        logic [DATA_W-1:0] data;
        logic              nack;
    } eeprom_rsp_t;

endpackage

// ==== verilog/i2c_eeprom_ctrl.sv ====
`timescale 1ns/1ps
module i2c_eeprom_ctrl (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  start,
    input  eeprom_pkg::ctrl_req_t req,
    output logic                  done,
    output eeprom_pkg::ctrl_rsp_t rsp,
    output logic                  scl,
    output logic                  sda_low,
    input  logic                  sda_in
);
    import eeprom_pkg::*;

    logic [NUM_PHASE-1:0] st;
    logic [NUM_PHASE-1:0] st_nxt;
    logic [QCNT_W-1:0]    qcnt;
    logic [1:0]           q;        // quarter within the scl period
    logic [3:0]           bcnt;     // bit slot within a byte, 8 is the ack
    logic [DATA_W-1:0]    tx_sh;
    logic [DATA_W-1:0]    rx_sh;
    logic                 ack_hi;   // ninth bit as sampled, high means nack
    ctrl_req_t            req_q;
    logic                 tick;
    logic                 samp;
    logic                 ph_end;
    logic                 tx_ph;
    logic                 byte_ph;
    logic                 last_bit;

    function automatic logic [NUM_PHASE-1:0] ph(input int idx);
        ph      = '0;
        ph[idx] = 1'b1;
    endfunction

    assign tick     = (qcnt == QCNT_W'(QUARTER - 1));
    assign samp     = tick && (q == 2'd2);     // middle of scl high
    assign ph_end   = tick && (q == 2'd3);
    assign tx_ph    = st[P_CTRL_WR] | st[P_ADDR] | st[P_DATA] | st[P_CTRL_RD];
    assign byte_ph  = tx_ph | st[P_DATA_RD];
    assign last_bit = (bcnt == 4'd8);
    assign done     = st[P_DONE];

    // bus waveform per phase and quarter
    always_comb
    begin
        scl     = 1'b1;
        sda_low = 1'b0;
        if (st[P_START])
        begin
            scl     = (q != 2'd3);
            sda_low = (q != 2'd0);          // falls in q1 with scl high
        end
        else if (st[P_RSTART])
        begin
            scl     = (q == 2'd1) || (q == 2'd2);
            sda_low = q[1];                 // falls in q2 with scl high
        end
        else if (st[P_STOP])
        begin
            scl     = (q != 2'd0);
            sda_low = !q[1];                // rises in q2 with scl high
        end
        else if (byte_ph)
        begin
            scl     = (q == 2'd1) || (q == 2'd2);
            sda_low = tx_ph && !last_bit && !tx_sh[DATA_W-1];
        end
    end

    always_comb
    begin
        st_nxt = st;
        if (st[P_IDLE] && start)
        begin
            st_nxt = ph(P_START);
        end
        else if (st[P_START] && ph_end)
        begin
            st_nxt = ph(P_CTRL_WR);
        end
        else if (st[P_RSTART] && ph_end)
        begin
            st_nxt = ph(P_CTRL_RD);
        end
        else if (byte_ph && ph_end && last_bit)
        begin
            if (tx_ph && ack_hi)
            begin
                st_nxt = ph(P_STOP);        // slave did not acknowledge
            end
            else if (st[P_CTRL_WR])
            begin
                st_nxt = ph(P_ADDR);
            end
            else if (st[P_ADDR])
            begin
                st_nxt = req_q.write ? ph(P_DATA) : ph(P_RSTART);
            end
            else if (st[P_CTRL_RD])
            begin
                st_nxt = ph(P_DATA_RD);
            end
            else
            begin
                st_nxt = ph(P_STOP);
            end
        end
        else if (st[P_STOP] && ph_end)
        begin
            st_nxt = ph(P_DONE);
        end
        else if (st[P_DONE])
        begin
            st_nxt = ph(P_IDLE);
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            st   <= ph(P_IDLE);
            qcnt <= '0;
            q    <= 2'd0;
            bcnt <= 4'd0;
        end
        else
        begin
            st <= st_nxt;
            if (st[P_IDLE] || st[P_DONE])
            begin
                qcnt <= '0;
                q    <= 2'd0;
                bcnt <= 4'd0;
            end
            else
            begin
                qcnt <= tick ? '0 : qcnt + 1'b1;
                if (tick)
                    q <= q + 2'd1;
                if (byte_ph && ph_end)
                    bcnt <= last_bit ? 4'd0 : bcnt + 4'd1;
            end
        end
    end

    // shifters and response
    always_ff @(posedge CLK)
    begin
        if (st[P_IDLE] && start)
        begin
            req_q <= req;
            rsp   <= '0;
        end

        if (st[P_START] && ph_end)
            tx_sh <= {DEVICE_CODE, req_q.addr[ADDR_W-1:DATA_W], 1'b0};
        else if (st[P_RSTART] && ph_end)
            tx_sh <= {DEVICE_CODE, req_q.addr[ADDR_W-1:DATA_W], 1'b1};
        else if (byte_ph && ph_end && last_bit)
            tx_sh <= st[P_CTRL_WR] ? req_q.addr[DATA_W-1:0] : req_q.data;
        else if (tx_ph && ph_end)
            tx_sh <= {tx_sh[DATA_W-2:0], 1'b0};

        if (samp && last_bit)
            ack_hi <= sda_in;
        if (samp && st[P_DATA_RD] && !last_bit)
            rx_sh <= {rx_sh[DATA_W-2:0], sda_in};   // msb first

        if (tx_ph && ph_end && last_bit && ack_hi)
            rsp.nack <= 1'b1;
        if (st[P_DATA_RD] && ph_end && last_bit)
            rsp.data <= rx_sh;
    end

    a_idle_released: assert property (
        @(posedge CLK) disable iff (RESET)
        st[P_IDLE] |-> (scl && !sda_low))
        else $error("bus not released while idle");

    a_start_idle: assert property (
        @(posedge CLK) disable iff (RESET)
        start |-> st[P_IDLE])
        else $error("start during a transaction");

endmodule

// ==== verilog/req_dispatch.sv ====
`timescale 1ns/1ps
module req_dispatch (
    input  logic                                CLK,
    input  logic                                RESET,
    input  logic                                req_valid,
    input  eeprom_pkg::eeprom_req_t             req,
    input  logic [eeprom_pkg::NUM_CHAN-1:0]     done,
    output logic [eeprom_pkg::NUM_CHAN-1:0]     start,
    output eeprom_pkg::ctrl_req_t               ctrl_req,
    output logic [eeprom_pkg::NUM_CHAN-1:0]     busy,
    output logic [eeprom_pkg::NUM_CHAN-1:0]     write_tag
);
    import eeprom_pkg::*;

    logic [NUM_CHAN-1:0] sel;

    // channel decode
    always_comb
    begin
        sel = '0;
        if (req_valid)
            sel = NUM_CHAN'(1) << req.chan;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            start <= '0;
            busy  <= '0;
        end
        else
        begin
            start <= sel;
            busy  <= (busy | sel) & ~done;
        end
    end

    // broadcast request, only the started channel latches it
    always_ff @(posedge CLK)
    begin
        if (req_valid)
            ctrl_req <= '{write: req.write, addr: req.addr, data: req.data};
        for (int i = 0; i < NUM_CHAN; i++)
        begin
            if (sel[i])
                write_tag[i] <= req.write;
        end
    end

    a_no_busy_target: assert property (
        @(posedge CLK) disable iff (RESET)
        req_valid |-> !busy[req.chan])
        else $error("request aimed at a busy channel");

endmodule

// ==== verilog/rsp_collect.sv ====
`timescale 1ns/1ps
module rsp_collect (
    input  logic                                             CLK,
    input  logic                                             RESET,
    input  logic [eeprom_pkg::NUM_CHAN-1:0]                  done,
    input  eeprom_pkg::ctrl_rsp_t [eeprom_pkg::NUM_CHAN-1:0] ctrl_rsp,
    input  logic [eeprom_pkg::NUM_CHAN-1:0]                  write_tag,
    output logic                                             rsp_valid,
    output eeprom_pkg::eeprom_rsp_t                          rsp
);
    import eeprom_pkg::*;

    logic [NUM_CHAN-1:0]      pend;
    logic [NUM_CHAN-1:0]      grant;
    ctrl_rsp_t [NUM_CHAN-1:0] slot;
    logic [NUM_CHAN-1:0]      slot_wr;  // write flag captured with the response
    logic [CHAN_W-1:0]        sel;

    // lowest pending channel wins
    always_comb
    begin
        sel = '0;
        for (int i = NUM_CHAN - 1; i >= 0; i--)
        begin
            if (pend[i])
                sel = CHAN_W'(i);
        end
        grant = pend & (~pend + NUM_CHAN'(1));
    end

    assign rsp_valid = |pend;
    assign rsp.chan  = sel;
    assign rsp.write = slot_wr[sel];
    assign rsp.data  = slot[sel].data;
    assign rsp.nack  = slot[sel].nack;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            pend <= '0;
        else
            pend <= (pend & ~grant) | done;
    end

    always_ff @(posedge CLK)
    begin
        for (int i = 0; i < NUM_CHAN; i++)
        begin
            if (done[i])
            begin
                slot[i]    <= ctrl_rsp[i];
                slot_wr[i] <= write_tag[i];
            end
        end
    end

    a_no_overwrite: assert property (
        @(posedge CLK) disable iff (RESET)
        (done & pend) == '0)
        else $error("completion on a channel with a pending response");

endmodule

// ==== verilog/eeprom_bus_top.sv ====
`timescale 1ns/1ps
module eeprom_bus_top (
    input  logic                            CLK,
    input  logic                            RESET,
    input  logic                            req_valid,
    input  eeprom_pkg::eeprom_req_t         req,
    output logic [eeprom_pkg::NUM_CHAN-1:0] busy,
    output logic                            rsp_valid,
    output eeprom_pkg::eeprom_rsp_t         rsp,
    output logic [eeprom_pkg::NUM_CHAN-1:0] scl,
    output logic [eeprom_pkg::NUM_CHAN-1:0] sda_low,
    input  logic [eeprom_pkg::NUM_CHAN-1:0] sda_in
);
    import eeprom_pkg::*;

    logic [NUM_CHAN-1:0]      start;
    logic [NUM_CHAN-1:0]      done;
    logic [NUM_CHAN-1:0]      write_tag;
    ctrl_req_t                ctrl_req;
    ctrl_rsp_t [NUM_CHAN-1:0] ctrl_rsp;

    req_dispatch req_dispatch_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .done      (done),
        .start     (start),
        .ctrl_req  (ctrl_req),
        .busy      (busy),
        .write_tag (write_tag)
    );

    // one bus controller per channel
    for (genvar i = 0; i < NUM_CHAN; i++)
    begin : g_chan
        i2c_eeprom_ctrl i2c_eeprom_ctrl_inst (
            .CLK     (CLK),
            .RESET   (RESET),
            .start   (start[i]),
            .req     (ctrl_req),
            .done    (done[i]),
            .rsp     (ctrl_rsp[i]),
            .scl     (scl[i]),
            .sda_low (sda_low[i]),
            .sda_in  (sda_in[i])
        );
    end

    rsp_collect rsp_collect_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .done      (done),
        .ctrl_rsp  (ctrl_rsp),
        .write_tag (write_tag),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

// ==== tb/eeprom_model.sv ====
`timescale 1ns/1ps
module eeprom_model #(
    parameter int NUM_BLOCKS = 4
) (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic sda_low,
    output logic proto_err
);
    import eeprom_pkg::*;

    logic [DATA_W-1:0] mem [NUM_BLOCKS*256];
    logic              scl_q;
    logic              sda_q;
    logic              active;     // between start and stop
    logic [3:0]        bitn;       // 8 is the ack slot
    logic [2:0]        phase;      // 0 ctrl, 1 addr, 2 data or restart, 3 read out, 4 ignore
    logic [DATA_W-1:0] rxd;
    logic [DATA_W-1:0] txd;
    logic [DATA_W-1:0] lo;
    logic [2:0]        blk;

    initial
    begin
        for (int a = 0; a < NUM_BLOCKS * 256; a++)
            mem[a] = 8'(a * 37 + (a >> 8));
    end

    task automatic protocol_error(input string msg);
        $display("protocol error at %0t ns: %s", $time, msg);
        proto_err <= 1'b1;
    endtask

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            active    <= 1'b0;
            bitn      <= 4'd0;
            phase     <= 3'd4;
            sda_low   <= 1'b0;
            proto_err <= 1'b0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl_q && scl && (sda_q != sda))
            begin
                // only start or stop may move sda with scl high
                if (bitn != 4'd0)
                    protocol_error("sda changed while scl high inside a byte");
                if (!sda)
                begin
                    if (active && phase != 3'd2)
                        protocol_error("repeated start out of place");
                    active  <= 1'b1;
                    phase   <= 3'd0;
                    bitn    <= 4'd8;    // next scl fall opens the byte
                    sda_low <= 1'b0;
                end
                else
                begin
                    if (!active)
                        protocol_error("stop without start");
                    active <= 1'b0;
                    phase  <= 3'd4;
                end
            end
            else if (!scl_q && scl)
            begin
                if (!active)
                    protocol_error("scl pulse outside a transaction");
                if (bitn < 4'd8)
                    rxd <= {rxd[DATA_W-2:0], sda};
            end
            else if (scl_q && !scl && active)
            begin
                if (bitn < 4'd7)
                begin
                    bitn <= bitn + 4'd1;
                    if (phase == 3'd3)
                        sda_low <= !txd[6 - bitn];
                end
                else if (bitn == 4'd7)
                begin
                    bitn    <= 4'd8;
                    sda_low <= 1'b0;
                    case (phase)
                        3'd0:
                        begin
                            if (rxd[7:4] != DEVICE_CODE)
                                protocol_error("control byte without device code");
                            if (rxd[7:4] == DEVICE_CODE && rxd[3:1] < NUM_BLOCKS)
                            begin
                                sda_low <= 1'b1;
                                blk     <= rxd[3:1];
                                phase   <= rxd[0] ? 3'd3 : 3'd1;
                                txd     <= mem[{rxd[3:1], lo}];
                            end
                            else
                                phase <= 3'd4;  // unpopulated block, no ack
                        end
                        3'd1:
                        begin
                            lo      <= rxd;
                            sda_low <= 1'b1;
                            phase   <= 3'd2;
                        end
                        3'd2:
                        begin
                            mem[{blk, lo}] <= rxd;
                            sda_low        <= 1'b1;
                            phase          <= 3'd4;
                        end
                        3'd3:
                            phase <= 3'd4;      // master acks or nacks now
                        default:
                            phase <= 3'd4;
                    endcase
                end
                else
                begin
                    bitn    <= 4'd0;
                    sda_low <= (phase == 3'd3) ? !txd[DATA_W-1] : 1'b0;
                end
            end
        end
    end

endmodule

// ==== tb/tb_eeprom_bus.sv ====
`timescale 1ns/1ps
module tb_eeprom_bus;
    import eeprom_pkg::*;

    logic                CLK;
    logic                RESET;
    logic                req_valid;
    eeprom_req_t         req;
    logic [NUM_CHAN-1:0] busy;
    logic                rsp_valid;
    eeprom_rsp_t         rsp;
    logic [NUM_CHAN-1:0] scl;
    logic [NUM_CHAN-1:0] sda_low;
    logic [NUM_CHAN-1:0] sda_in;
    logic [NUM_CHAN-1:0] model_low;
    logic [NUM_CHAN-1:0] proto_err;
    logic [DATA_W-1:0]   ref_mem [NUM_CHAN][1 << ADDR_W];
    logic [DATA_W+1:0]   issue_exp;              // {write, data, nack}
    logic [DATA_W+1:0]   exp_q0 [$];
    logic [DATA_W+1:0]   exp_q1 [$];
    logic                last_valid;
    logic [CHAN_W-1:0]   last_chan;
    integer              seed;

    always #50 CLK = ~CLK;

    eeprom_bus_top eeprom_bus_top_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .scl       (scl),
        .sda_low   (sda_low),
        .sda_in    (sda_in)
    );

    for (genvar i = 0; i < NUM_CHAN; i++)
    begin : g_model
        assign sda_in[i] = !(sda_low[i] | model_low[i]);   // wired-AND
        eeprom_model #(.NUM_BLOCKS(4)) eeprom_model_inst (
            .CLK       (CLK),
            .RESET     (RESET),
            .scl       (scl[i]),
            .sda       (sda_in[i]),
            .sda_low   (model_low[i]),
            .proto_err (proto_err[i])
        );
    end

    task automatic report_error(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic int outstanding(input int c);
        return (c == 0) ? exp_q0.size() : exp_q1.size();
    endfunction

    task automatic issue(input logic wr, input int c, input logic [ADDR_W-1:0] a,
                         input logic [DATA_W-1:0] d);
        logic bad;
        bad = (a[ADDR_W-1:DATA_W] >= 3'd4);
        while (busy[c] || outstanding(c) != 0)
            @(negedge CLK);
        req_valid = 1'b1;
        req       = '{write: wr, chan: CHAN_W'(c), addr: a, data: d};
        issue_exp = {wr, wr ? 8'h00 : ref_mem[c][a], bad};
        if (wr && !bad)
            ref_mem[c][a] = d;
        @(negedge CLK);
        req_valid = 1'b0;
    endtask

    always @(posedge CLK)
    begin
        logic [DATA_W+1:0] want;
        if (!RESET)
        begin
            a_proto: assert (proto_err == '0)
                else report_error("bus protocol violation seen by an EEPROM model");
            if (last_valid)
                a_busy_rise: assert (busy[last_chan])
                    else report_error("busy did not rise after a request");
            for (int c = 0; c < NUM_CHAN; c++)
                a_busy_held: assert (busy[c] || outstanding(c) == 0 || rsp_valid)
                    else report_error($sformatf("busy low on channel %0d with work open", c));
            if (rsp_valid)
            begin
                a_rsp_known: assert (outstanding(int'(rsp.chan)) != 0)
                    else report_error("response without a request");
                want = (rsp.chan == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
                a_rsp_tags: assert (rsp.write == want[DATA_W+1] && rsp.nack == want[0])
                    else report_error($sformatf("chan %0d write %0b nack %0b, expected %0b %0b",
                        rsp.chan, rsp.write, rsp.nack, want[DATA_W+1], want[0]));
                if (!want[DATA_W+1] && !want[0])
                    a_rsp_data: assert (rsp.data == want[DATA_W:1])
                        else report_error($sformatf("chan %0d read data %h, expected %h",
                            rsp.chan, rsp.data, want[DATA_W:1]));
            end
            if (req_valid && req.chan == 0)
                exp_q0.push_back(issue_exp);
            else if (req_valid)
                exp_q1.push_back(issue_exp);
        end
        last_valid <= req_valid && !RESET;
        last_chan  <= req.chan;
    end

    // 60 transactions of at most 400 cycles
    initial
    begin
        #(60 * 400 * 100);
        $display("watchdog timeout, responses missing");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d0;
        logic [DATA_W-1:0] d1;
        logic [2:0]        blk;
        seed      = 61;
        CLK       = 1'b0;
        RESET     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        issue_exp = '0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        repeat (2) @(negedge CLK);

        // same address on both channels, different data
        for (int n = 0; n < 10; n++)
        begin
            a  = ADDR_W'($random(seed)) & 11'h3ff;
            d0 = 8'($random(seed));
            d1 = 8'($random(seed));
            if (d1 == d0)
                d1 = ~d0;
            issue(1'b1, 0, a, d0);
            issue(1'b1, 1, a, d1);
            issue(1'b0, 0, a, 8'h00);
            issue(1'b0, 1, a, 8'h00);
        end

        // blocks 4 to 7 are not populated
        for (int n = 0; n < 3; n++)
        begin
            a   = ADDR_W'($random(seed)) & 11'h3ff;
            d0  = 8'($random(seed));
            blk = {1'b1, a[9:8]};       // aliases a without its top bit
            issue(1'b1, n % 2, a, d0);
            issue(1'b1, n % 2, {blk, a[7:0]}, ~d0);
            issue(1'b0, n % 2, {blk, a[7:0]}, 8'h00);
            issue(1'b0, n % 2, a, 8'h00);
        end

        while (exp_q0.size() + exp_q1.size() != 0)
            @(negedge CLK);
        repeat (4) @(negedge CLK);
        a_bus_idle: assert (!g_model[0].eeprom_model_inst.active &&
                            !g_model[1].eeprom_model_inst.active)
            else report_error("a transaction did not end with a stop");
        $display("Test OK");
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/eeprom_pkg.sv
verilog/i2c_eeprom_ctrl.sv
verilog/req_dispatch.sv
verilog/rsp_collect.sv
verilog/eeprom_bus_top.sv
tb/eeprom_model.sv
tb/tb_eeprom_bus.sv

// ==== Makefile ====
TOP = tb_eeprom_bus

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
